//--- matrix_decoder.f
source/ahb_pkg.sv
source/map_pkg.sv
source/region_decoder.sv
source/port_select.sv
source/default_slave.sv
source/response_mux.sv
source/matrix_decoder.sv
verif/tb_clock.sv
verif/tb_matrix_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the matrix decoder testbench with Verilator
set -u

BUILD_DIR=obj_dir
SIM_EXE=sim_matrix_decoder

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f matrix_decoder.f \
    --top-module tb_matrix_decoder \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_EXE"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/$SIM_EXE"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
fi
exit "$status"

//--- source/ahb_pkg.sv
package ahb_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int DATA_WIDTH   = 32;  // HRDATA width
    localparam int DEC_ADDR_MSB = 31;  // Top of decoded HADDR slice
    localparam int DEC_ADDR_LSB = 10;  // 1 KB decode granularity

    // Upper HADDR bits seen by the decoder
    typedef logic [DEC_ADDR_MSB:DEC_ADDR_LSB] dec_addr_t;

    // ------------------------------
    // AHB encodings
    // ------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01,
        RETRY = 2'b10,  // Legacy AHB2 code
        SPLIT = 2'b11   // Legacy AHB2 code
    } hresp_t;

    // ------------------------------
    // Bundles
    // ------------------------------
    // Address phase from the input stage
    typedef struct packed {
        logic      sel;       // HSEL into this decoder
        dec_addr_t dec_addr;  // HADDR[31:10]
        htrans_t   trans;     // HTRANS
    } ahb_req_t;

    // Return path of one subordinate port
    typedef struct packed {
        logic                  active;    // Output stage owns this master
        logic                  readyout;  // HREADYOUT
        hresp_t                resp;      // HRESP
        logic [DATA_WIDTH-1:0] rdata;     // HRDATA
    } sub_resp_t;

    // Data-phase response back to the input stage
    typedef struct packed {
        logic                  readyout;  // HREADYOUTS
        hresp_t                resp;      // HRESPS
        logic [DATA_WIDTH-1:0] rdata;     // HRDATAS
    } ahb_resp_t;

endpackage

//--- source/default_slave.sv
module default_slave
    import ahb_pkg::*;
(
    input  logic    HCLK,          // AHB clock
    input  logic    HRESETn,       // Sync reset, active low
    input  logic    HREADYS,       // Input stage HREADY
    input  logic    sel_dft,       // Selected for an unmapped address
    input  htrans_t trans,         // HTRANS of the address phase
    output logic    dft_readyout,  // HREADYOUT of the default slave
    output hresp_t  dft_resp       // HRESP of the default slave
);

    // ------------------------------
    // State
    // ------------------------------
    typedef enum logic [1:0] {
        dft_idle = 2'b00,  // OKAY, ready
        dft_err1 = 2'b01,  // ERROR, wait state
        dft_err2 = 2'b10   // ERROR, ready
    } dft_state_t;

    dft_state_t state;
    dft_state_t state_next;
    logic       trans_req;  // Active transfer accepted this edge

    // IDLE and BUSY get a zero wait OKAY
    assign trans_req = sel_dft & HREADYS & ((trans == NONSEQ) | (trans == SEQ));

    always_comb
    begin
        case (state)
            dft_idle: state_next = trans_req ? dft_err1 : dft_idle;
            // Own readyout is low here, so no HREADYS wait
            dft_err1: state_next = dft_err2;
            // Back-to-back unmapped transfer restarts the sequence
            dft_err2: state_next = trans_req ? dft_err1 : dft_idle;
            default:  state_next = dft_idle;
        endcase
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            state <= dft_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign dft_readyout = (state != dft_err1);                  // Low in first cycle only
    assign dft_resp     = (state == dft_idle) ? OKAY : ERROR;   // Two-cycle ERROR

    // Wait cycle of an ERROR is followed by the ready ERROR cycle
    a_err_two_cycle: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        !dft_readyout |=> dft_readyout && (dft_resp == ERROR)
    ) else $error("default_slave: ERROR response not two cycles");

endmodule

//--- source/map_pkg.sv
package map_pkg;

    // ------------------------------
    // Port coding
    // ------------------------------
    localparam int MAX_PORTS = 6;  // Entries in the region table

    // Codes 1..6 are subordinates, 8 is the local default slave
    typedef logic [3:0] port_idx_t;

    localparam port_idx_t DFT_PORT = 4'd8;  // Default slave code

    // ------------------------------
    // Region table
    // ------------------------------
    // One address window, both ends inclusive
    typedef struct packed {
        ahb_pkg::dec_addr_t base;   // First 1 KB block
        ahb_pkg::dec_addr_t limit;  // Last 1 KB block
    } region_t;

    // Values are HADDR >> 10, so they do not line up with hex digits
    // Entry 0 belongs to port 1, entry 5 to port 6
    localparam region_t REGION_MAP [MAX_PORTS] = '{
        // 0x20000000 - 0x2002FFFF
        '{base: 22'h080000, limit: 22'h0800BF},
        // 0x30000000 - 0x30003FFF
        '{base: 22'h0C0000, limit: 22'h0C000F},
        // 0x40000000 - 0x4004FFFF
        '{base: 22'h100000, limit: 22'h10013F},
        // 0x50000000 - 0x5007FFFF
        '{base: 22'h140000, limit: 22'h1401FF},
        // 0x60000000 - 0x6001FFFF
        '{base: 22'h180000, limit: 22'h18007F},
        // 0x70000000 - 0x7001FFFF
        '{base: 22'h1C0000, limit: 22'h1C007F}
    };

endpackage

//--- source/matrix_decoder.sv
module matrix_decoder
    import ahb_pkg::*, map_pkg::*;
#(
    parameter int NUM_PORTS = 6  // Subordinate ports on this input
)
(
    input  logic                 HCLK,                  // AHB clock
    input  logic                 HRESETn,               // Sync reset, active low
    input  logic                 HREADYS,               // Input stage HREADY
    input  ahb_req_t             req,                   // Address phase
    input  sub_resp_t            sub_resp [NUM_PORTS],  // Output stage returns
    output logic [NUM_PORTS-1:0] sel_ports,             // HSEL per port
    output logic                 active_dec,            // Active of chosen port
    output ahb_resp_t            rsp                    // HREADYOUTS, HRESPS, HRDATAS
);

    port_idx_t            addr_port;     // Address-phase port
    port_idx_t            data_port;     // Data-phase port
    logic [NUM_PORTS-1:0] sub_active;    // Active flags only
    logic                 sel_dft;       // Default slave select
    logic                 dft_readyout;
    hresp_t               dft_resp;

    // Active flags gathered from the return bundles
    for (genvar k = 0; k < NUM_PORTS; k++)
    begin : g_active
        assign sub_active[k] = sub_resp[k].active;
    end

    // ------------------------------
    // Address phase
    // ------------------------------
    region_decoder #(
        .NUM_PORTS (NUM_PORTS)
    ) region_decoder_inst (
        .req       (req),
        .data_port (data_port),
        .addr_port (addr_port)
    );

    port_select #(
        .NUM_PORTS (NUM_PORTS)
    ) port_select_inst (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HREADYS    (HREADYS),
        .sel        (req.sel),
        .addr_port  (addr_port),
        .sub_active (sub_active),
        .sel_ports  (sel_ports),
        .sel_dft    (sel_dft),
        .active_dec (active_dec),
        .data_port  (data_port)
    );

    // Unmapped accesses land here
    default_slave default_slave_inst (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .HREADYS      (HREADYS),
        .sel_dft      (sel_dft),
        .trans        (req.trans),
        .dft_readyout (dft_readyout),
        .dft_resp     (dft_resp)
    );

    // ------------------------------
    // Data phase
    // ------------------------------
    response_mux #(
        .NUM_PORTS (NUM_PORTS)
    ) response_mux_inst (
        .data_port    (data_port),
        .sub_resp     (sub_resp),
        .dft_readyout (dft_readyout),
        .dft_resp     (dft_resp),
        .rsp          (rsp)
    );

endmodule

//--- source/port_select.sv
module port_select
    import map_pkg::*;
#(
    parameter int NUM_PORTS = 6  // Number of subordinate ports
)
(
    input  logic                 HCLK,        // AHB clock
    input  logic                 HRESETn,     // Sync reset, active low
    input  logic                 HREADYS,     // Input stage HREADY
    input  logic                 sel,         // HSEL from input stage
    input  port_idx_t            addr_port,   // Address-phase port
    input  logic [NUM_PORTS-1:0] sub_active,  // Active flags of ports
    output logic [NUM_PORTS-1:0] sel_ports,   // HSEL per subordinate port
    output logic                 sel_dft,     // HSEL for default slave
    output logic                 active_dec,  // Active of chosen port
    output port_idx_t            data_port    // Data-phase owner
);

    logic [NUM_PORTS-1:0] port_hit;  // One-hot of addr_port
    logic                 dft_hit;   // addr_port is the default slave

    // ------------------------------
    // Address-phase decode
    // ------------------------------
    always_comb
    begin
        port_hit = '0;
        for (int k = 0; k < NUM_PORTS; k++)
        begin
            port_hit[k] = (addr_port == port_idx_t'(k + 1));
        end
    end

    assign dft_hit = (addr_port == DFT_PORT);

    // Selects only when this master is addressed
    assign sel_ports = port_hit & {NUM_PORTS{sel}};
    assign sel_dft   = dft_hit & sel;

    // Active flag of the chosen output stage
    // Default slave is always ready to take the transfer
    assign active_dec = dft_hit | (|(port_hit & sub_active));

    // ------------------------------
    // Data-phase port register
    // ------------------------------
    // HREADYS, not the muxed readyout, marks the end of each address phase
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            data_port <= DFT_PORT;  // Default slave idles with readyout high
        end
        else if (HREADYS)
        begin
            data_port <= addr_port;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_sel_onehot0: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        $onehot0({sel_ports, sel_dft})
    ) else $error("port_select: more than one select high");

endmodule

//--- source/region_decoder.sv
module region_decoder
    import ahb_pkg::*, map_pkg::*;
#(
    parameter int NUM_PORTS = 6  // Live entries of REGION_MAP
)
(
    input  ahb_req_t  req,        // Address phase from input stage
    input  port_idx_t data_port,  // Port owning the data phase
    output port_idx_t addr_port   // Port chosen for this address phase
);

    // ------------------------------
    // Elaboration checks
    // ------------------------------
    if (NUM_PORTS < 1 || NUM_PORTS > MAX_PORTS)
    begin : g_bad_num_ports
        $error("region_decoder: NUM_PORTS must be 1 to %0d", MAX_PORTS);
    end

    logic [NUM_PORTS-1:0] in_range;   // Address falls in window k
    logic [NUM_PORTS-1:0] idle_hold;  // IDLE while port k has data phase

    // ------------------------------
    // Per-region tests
    // ------------------------------
    for (genvar k = 0; k < NUM_PORTS; k++)
    begin : g_region
        // Inclusive range compare on HADDR[31:10]
        assign in_range[k] = (req.dec_addr >= REGION_MAP[k].base) &&
                             (req.dec_addr <= REGION_MAP[k].limit);

        // Keep the current owner selected across IDLE transfers
        // so its output stage does not lose the master mid-burst
        assign idle_hold[k] = (data_port == port_idx_t'(k + 1)) &&
                              (req.trans == IDLE);
    end

    // ------------------------------
    // Priority pick
    // ------------------------------
    // Walked from the top down so the lowest matching port wins
    always_comb
    begin
        addr_port = DFT_PORT;  // Unmapped goes to default slave
        for (int k = NUM_PORTS - 1; k >= 0; k--)
        begin
            if (in_range[k] || idle_hold[k])
            begin
                addr_port = port_idx_t'(k + 1);
            end
        end
    end

    // Only live subordinate codes or the default slave leave here
    always_comb
    begin
        a_addr_port_legal: assert ((addr_port >= port_idx_t'(1) &&
                                    addr_port <= port_idx_t'(NUM_PORTS)) ||
                                   addr_port == DFT_PORT)
            else $error("region_decoder: illegal addr_port %0d", addr_port);
    end

endmodule

//--- source/response_mux.sv
module response_mux
    import ahb_pkg::*, map_pkg::*;
#(
    parameter int NUM_PORTS = 6  // Number of subordinate ports
)
(
    input  port_idx_t data_port,              // Data-phase owner
    input  sub_resp_t sub_resp [NUM_PORTS],   // Subordinate returns
    input  logic      dft_readyout,           // Default slave HREADYOUT
    input  hresp_t    dft_resp,               // Default slave HRESP
    output ahb_resp_t rsp                     // Back to input stage
);

    // ------------------------------
    // Response select
    // ------------------------------
    // Keyed on the registered data_port, never on addr_port
    always_comb
    begin
        // Default slave drives no read data
        rsp = '{readyout: dft_readyout, resp: dft_resp, rdata: '0};

        for (int k = 0; k < NUM_PORTS; k++)
        begin
            if (data_port == port_idx_t'(k + 1))
            begin
                rsp.readyout = sub_resp[k].readyout;  // HREADYOUT
                rsp.resp     = sub_resp[k].resp;      // HRESP
                rsp.rdata    = sub_resp[k].rdata;     // HRDATA
            end
        end
    end

endmodule

//--- verif/tb_clock.sv
module tb_clock
#(
    parameter int PERIOD = 40  // Clock period in time units
)
(
    output logic clk  // Free-running HCLK
);

    // ------------------------------
    // Clock generation
    // ------------------------------
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD / 2) clk = ~clk;  // Half period per phase
        end
    end

endmodule

//--- verif/tb_matrix_decoder.sv
module tb_matrix_decoder
    import ahb_pkg::*;
;

    localparam int NUM_PORTS     = 6;
    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_TRANSFERS = 400;
    localparam int MAX_CYCLES    = 5 * NUM_TRANSFERS;  // Run needs about 420 cycles

    localparam logic [3:0] DFT_CODE = 4'd8;  // Default slave port code

    // Memory map in full HADDR terms, port 1 first
    localparam logic [31:0] REGION_BASE [NUM_PORTS] = '{
        32'h2000_0000, 32'h3000_0000, 32'h4000_0000,
        32'h5000_0000, 32'h6000_0000, 32'h7000_0000
    };
    localparam logic [31:0] REGION_LIMIT [NUM_PORTS] = '{
        32'h2002_FFFF, 32'h3000_3FFF, 32'h4004_FFFF,
        32'h5007_FFFF, 32'h6001_FFFF, 32'h7001_FFFF
    };

    logic                 HCLK;
    logic                 HRESETn;
    logic                 HREADYS;
    ahb_req_t             req;
    sub_resp_t            sub_resp [NUM_PORTS];
    logic [NUM_PORTS-1:0] sel_ports;
    logic                 active_dec;
    ahb_resp_t            rsp;

    integer      seed = 26441;  // Fixed stimulus seed
    logic [31:0] cur_addr;      // Full HADDR behind req.dec_addr
    logic [3:0]  model_port;    // Expected data-phase owner
    int          model_state;   // 0 idle, 1 first ERROR, 2 second ERROR
    logic        model_valid = 1'b0;
    int          cycle_count = 0;

    tb_clock #(
        .PERIOD (CLK_PERIOD)
    ) tb_clock_inst (
        .clk (HCLK)
    );

    matrix_decoder #(
        .NUM_PORTS (NUM_PORTS)
    ) matrix_decoder_inst (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HREADYS    (HREADYS),
        .req        (req),
        .sub_resp   (sub_resp),
        .sel_ports  (sel_ports),
        .active_dec (active_dec),
        .rsp        (rsp)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic int unsigned pick(input int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;  // Uniform-ish in 0..n-1
    endfunction

    // Lowest port that matches by range or by IDLE hold, else default slave
    function automatic logic [3:0] expected_port(input logic [31:0] addr,
                                                 input htrans_t trans,
                                                 input logic [3:0] owner);
        logic [3:0] port;
        port = DFT_CODE;
        for (int k = NUM_PORTS; k >= 1; k--)
        begin
            if ((addr >= REGION_BASE[k-1] && addr <= REGION_LIMIT[k-1]) ||
                (owner == 4'(k) && trans == IDLE))
            begin
                port = 4'(k);
            end
        end
        return port;
    endfunction

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
        if (got !== want)
        begin
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, want);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first wrong value");
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic randomize_returns();
        for (int k = 0; k < NUM_PORTS; k++)
        begin
            sub_resp[k].active   = (pick(2) != 0);
            sub_resp[k].readyout = (pick(4) != 0);  // Mostly ready
            sub_resp[k].resp     = hresp_t'(2'(pick(4)));
            sub_resp[k].rdata    = 32'h1111_1111 * 32'(k + 1);  // Fixed per port
        end
    endtask

    task automatic drive_transfer();
        int unsigned p;
        int unsigned kind;
        logic [31:0] addr;
        p    = pick(NUM_PORTS);
        kind = pick(8);
        if (kind < 5)
        begin
            case (pick(4))
                0:       addr = REGION_BASE[p];   // Base edge
                1:       addr = REGION_LIMIT[p];  // Limit edge
                default: addr = REGION_BASE[p] + pick(REGION_LIMIT[p] - REGION_BASE[p] + 1);
            endcase
        end
        else if (kind == 5)
        begin
            addr = REGION_LIMIT[p] + 1 + pick(32'h0001_0000);  // Gap after a region
        end
        else if (kind == 6)
        begin
            addr = pick(32'h2000_0000);  // Below port 1
        end
        else
        begin
            addr = 32'h8000_0000 | pick(32'h8000_0000);  // Above port 6
        end
        cur_addr     = addr;
        req.sel      = (pick(8) != 0);
        req.dec_addr = addr[31:10];
        req.trans    = htrans_t'(2'(pick(4)));
        HREADYS      = (pick(4) != 0);  // Some back-pressure
    endtask

    initial
    begin
        HRESETn  = 1'b0;
        HREADYS  = 1'b1;
        cur_addr = '0;
        req      = '{sel: 1'b0, dec_addr: '0, trans: IDLE};
        for (int k = 0; k < NUM_PORTS; k++)
        begin
            sub_resp[k] = '{active: 1'b0, readyout: 1'b1, resp: OKAY, rdata: '0};
        end
        repeat (RESET_CYCLES)
        begin
            @(negedge HCLK);
            randomize_returns();
            drive_transfer();
        end
        for (int n = 0; n < NUM_TRANSFERS; n++)
        begin
            @(negedge HCLK);
            HRESETn = 1'b1;  // Released with the first transfer
            randomize_returns();
            drive_transfer();
        end
        // Let the last data phase be checked
        @(negedge HCLK);
        req.sel   = 1'b0;
        req.trans = IDLE;
        HREADYS   = 1'b1;
        @(posedge HCLK);
        $display("Simulation PASSED");
        $finish;
    end

    // ------------------------------
    // Reference state
    // ------------------------------
    always @(posedge HCLK)
    begin : model_update
        logic [3:0] next_port;
        logic       err_req;
        next_port = expected_port(cur_addr, req.trans, model_port);
        err_req   = req.sel && HREADYS && (next_port == DFT_CODE) &&
                    (req.trans == NONSEQ || req.trans == SEQ);
        if (!HRESETn)
        begin
            model_port  = DFT_CODE;
            model_state = 0;
        end
        else
        begin
            if (HREADYS)
            begin
                model_port = next_port;  // Address phase accepted
            end
            if (model_state == 1)
            begin
                model_state = 2;  // Wait cycle always ends
            end
            else
            begin
                model_state = err_req ? 1 : 0;
            end
        end
        model_valid = 1'b1;
    end

    // ------------------------------
    // Comparison
    // ------------------------------
    always @(negedge HCLK)
    begin : compare_outputs
        logic [3:0]           exp_port;
        logic [NUM_PORTS-1:0] exp_sel;
        logic                 exp_active;
        logic                 exp_ready;
        hresp_t               exp_resp;
        logic [31:0]          exp_rdata;
        #(CLK_PERIOD / 4);  // Inputs settled since the falling edge
        if (model_valid)
        begin
            exp_port   = expected_port(cur_addr, req.trans, model_port);
            exp_active = (exp_port == DFT_CODE);  // Default slave always active
            exp_ready  = (model_state != 1);
            exp_resp   = (model_state == 0) ? OKAY : ERROR;
            exp_rdata  = '0;
            for (int k = 0; k < NUM_PORTS; k++)
            begin
                exp_sel[k] = req.sel && (exp_port == 4'(k + 1));
                if (exp_port == 4'(k + 1))
                begin
                    exp_active = sub_resp[k].active;
                end
                if (model_port == 4'(k + 1))  // Data phase owner
                begin
                    exp_ready = sub_resp[k].readyout;
                    exp_resp  = sub_resp[k].resp;
                    exp_rdata = sub_resp[k].rdata;
                end
            end
            compare_value("sel_ports", 64'(sel_ports), 64'(exp_sel));
            compare_value("active_dec", 64'(active_dec), 64'(exp_active));
            compare_value("rsp.readyout", 64'(rsp.readyout), 64'(exp_ready));
            compare_value("rsp.resp", 64'(rsp.resp), 64'(exp_resp));
            compare_value("rsp.rdata", 64'(rsp.rdata), 64'(exp_rdata));
        end
    end

    // Guard against a stuck run
    always @(posedge HCLK)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule
